// ==== filelist.f ====
rtl/rr_pkg.sv
rtl/rr_apb_regs.sv
rtl/rr_req_slot.sv
rtl/rr_arbiter8.sv
rtl/rr_grant_log.sv
rtl/rr_arb_top.sv
verification/rr_arb_asserts.sv
verification/rr_arb_tb.sv

// ==== Bender.yml ====
package:
  name: rr_arb

sources:
  - rtl/rr_pkg.sv
  - rtl/rr_apb_regs.sv
  - rtl/rr_req_slot.sv
  - rtl/rr_arbiter8.sv
  - rtl/rr_grant_log.sv
  - rtl/rr_arb_top.sv
  - target: test
    files:
      - verification/rr_arb_asserts.sv
      - verification/rr_arb_tb.sv

// ==== verification/rr_arb_tb.sv ====
`timescale 1ns/1ps

module rr_arb_tb;
   import rr_pkg::*;

   localparam int clk_period = 8;
   localparam int max_cycles = 6000;  // all tests together with a wide margin.

   logic        clock;
   logic        reset;
   apb_req_t    apb_in;
   apb_rsp_t    apb_out;

   logic [7:0]  model_q [num_req][$];  // reference copy of every slot queue.
   int          model_last;
   logic [31:0] exp_q [$];  // expected log-pop read data, in grant order.
   logic [31:0] got_q [$];  // valid log-pop read data from the DUT.
   int          errors;
   int          checks;
   int          test_start;
   int          cycles;
   int          seed;
   int          total;
   logic [31:0] rdata;
   logic        rd_err;
   logic [7:0]  mask;

   rr_arb_top rr_arb_top_i (
      .clock   (clock),
      .reset   (reset),
      .apb_in  (apb_in),
      .apb_out (apb_out)
   );

   initial begin
      clock = 1'b0;
      forever #(clk_period / 2) clock = ~clock;
   end

   always @(posedge clock) begin
      cycles++;
      if (cycles >= max_cycles) begin
         $display("timeout after %0d cycles, the log never delivered the records", cycles);
         $display("ERRORS FOUND");
         $finish;
      end
   end

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   // setup on one falling edge, access on the next, sampled mid low phase.
   task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
      @(negedge clock);
      apb_in = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
      @(negedge clock);
      apb_in.penable = 1'b1;
      #2;
      err = apb_out.pslverr;
      check("pready", apb_out.pready, 1'b1);
      @(negedge clock);
      apb_in = '0;
   endtask

   task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
      @(negedge clock);
      apb_in = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: 32'h0};
      @(negedge clock);
      apb_in.penable = 1'b1;
      #2;
      data = apb_out.prdata;
      err  = apb_out.pslverr;
      check("pready", apb_out.pready, 1'b1);
      @(negedge clock);
      apb_in = '0;
   endtask

   // search below the last grant, wrapping, and end on the last grant itself.
   function automatic int next_grant(input logic [num_req-1:0] reqs, input int last);
      int cand;
      next_grant = -1;
      for (int k = 1; k <= num_req; k++) begin
         cand = (last - k + num_req) % num_req;
         if (next_grant < 0 && reqs[cand]) begin
            next_grant = cand;
         end
      end
   endfunction

   function automatic logic [num_req-1:0] pending();
      logic [num_req-1:0] v;
      for (int i = 0; i < num_req; i++) begin
         v[i] = (model_q[i].size() != 0);
      end
      return v;
   endfunction

   // arbitration runs freely once hold drops, so the whole grant order is known here.
   task automatic model_release();
      logic [num_req-1:0] reqs;
      logic [7:0]         data;
      int                 g;
      reqs = pending();
      while (reqs != '0) begin
         g    = next_grant(reqs, model_last);
         data = model_q[g].pop_front();
         exp_q.push_back({1'b1, 20'b0, 3'(g), data});
         model_last = g;
         reqs       = pending();
      end
   endtask

   task automatic write_slot(input int idx, input logic [7:0] data);
      logic full_exp;
      logic wr_err;
      full_exp = (model_q[idx].size() == slot_depth);
      apb_write(8'(addr_slot_base + 4 * idx), {24'b0, data}, wr_err);
      check("pslverr", wr_err, full_exp);
      if (!full_exp) begin
         model_q[idx].push_back(data);
      end
   endtask

   task automatic set_hold(input logic value);
      logic wr_err;
      apb_write(addr_ctrl, {31'b0, value}, wr_err);
      check("pslverr", wr_err, 1'b0);
      if (!value) begin
         model_release();
      end
   endtask

   task automatic wait_log_count(input int target, output logic [31:0] status);
      logic st_err;
      int   tries;
      tries  = 0;
      status = '0;
      do begin
         apb_read(addr_status, status, st_err);
         tries++;
      end while (status[11:8] < target && tries < 64);
      if (status[11:8] < target) begin
         errors++;
         $display("log count never reached %0d, last status %h", target, status);
      end
   endtask

   task automatic pop_records(input int n);
      logic [31:0] data;
      logic        pop_err;
      int          got;
      int          tries;
      got   = 0;
      tries = 0;
      while (got < n && tries < 8 * n + 16) begin
         apb_read(addr_log_pop, data, pop_err);
         tries++;
         if (data[31]) begin
            got_q.push_back(data);
            got++;
         end
      end
      if (got < n) begin
         errors++;
         $display("only %0d of %0d records came out of the grant log", got, n);
      end
   endtask

   task automatic finish_test(input string name);
      @(posedge clock);
      #1;
      check("records left unpopped", exp_q.size(), 0);
      $display("test %s: %s with %0d errors", name,
               (errors == test_start) ? "ok" : "failed", errors - test_start);
      test_start = errors;
   endtask

   // every popped record is compared with the next one the model predicts.
   always @(posedge clock) begin
      logic [31:0] got;
      if (got_q.size() > 0) begin
         got = got_q.pop_front();
         if (exp_q.size() == 0) begin
            errors++;
            $display("record %h was popped while none was expected", got);
         end else begin
            check("log_pop.prdata", got, exp_q.pop_front());
         end
      end
   end

   initial begin
      apb_in     = '0;
      reset      = 1'b0;
      errors     = 0;
      checks     = 0;
      test_start = 0;
      cycles     = 0;
      model_last = 0;  // the first search starts at 7.
      seed       = 32'h1421_fb6a;
      repeat (8) @(posedge clock);
      @(negedge clock);
      reset = 1'b1;

      apb_read(addr_status, rdata, rd_err);
      check("status.prdata", rdata, 32'h0);
      check("pslverr", rd_err, 1'b0);
      apb_read(addr_log_pop, rdata, rd_err);
      check("log_pop.prdata", rdata, 32'h0);
      check("pslverr", rd_err, 1'b0);
      apb_read(addr_ctrl, rdata, rd_err);
      check("ctrl.prdata", rdata, 32'h0);
      finish_test("reset state");

      write_slot(3, 8'h5a);
      model_release();
      wait_log_count(1, rdata);
      pop_records(1);
      finish_test("single request");

      set_hold(1'b1);
      for (int i = 0; i < num_req; i++) begin
         write_slot(i, 8'($random(seed)));
      end
      set_hold(1'b0);
      pop_records(num_req);
      finish_test("round robin order");

      set_hold(1'b1);
      repeat (3) write_slot(5, 8'($random(seed)));  // the third write hits a full slot.
      set_hold(1'b0);
      pop_records(slot_depth);
      finish_test("full slot");

      set_hold(1'b1);
      for (int n = 0; n < slot_depth; n++) begin
         for (int i = 0; i < num_req; i++) begin
            write_slot(i, 8'($random(seed)));
         end
      end
      set_hold(1'b0);
      wait_log_count(log_depth, rdata);
      // eight grants took one byte from every slot, so each one still requests.
      check("status.prdata", rdata, {20'b0, 4'(log_depth), 8'hff});
      pop_records(num_req * slot_depth);
      finish_test("back-pressure");

      for (int r = 0; r < 4; r++) begin
         set_hold(1'b1);
         mask  = 8'($random(seed));
         total = 0;
         for (int i = 0; i < num_req; i++) begin
            if (mask[i]) begin
               write_slot(i, 8'($random(seed)));
               total++;
               if ($random(seed) & 1) begin
                  write_slot(i, 8'($random(seed)));
                  total++;
               end
            end
         end
         set_hold(1'b0);
         pop_records(total);
      end
      finish_test("random sets");

      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

// ==== verification/rr_arb_asserts.sv ====
`timescale 1ns/1ps

module rr_arb_asserts (
   input logic                       clock,
   input logic                       reset,
   input logic [rr_pkg::num_req-1:0] req,
   input logic                       hold,
   input logic                       stall,
   input logic [rr_pkg::num_req-1:0] grant
);

   grant_onehot: assert property (@(posedge clock) disable iff (!reset) $onehot0(grant))
      else $error("grant has more than one bit set");

   // a held or stalled arbiter must stay idle.
   grant_idle: assert property (@(posedge clock) disable iff (!reset)
                                (hold || stall) |-> (grant == '0))
      else $error("grant issued while hold or stall is high");

   grant_requested: assert property (@(posedge clock) disable iff (!reset)
                                     ((grant & ~req) == '0))
      else $error("grant issued to a slot without a request");

   grant_progress: assert property (@(posedge clock) disable iff (!reset)
                                    ((req != '0) && !hold && !stall) |-> (grant != '0))
      else $error("request pending with no grant while arbitration is free");

endmodule

bind rr_arbiter8 rr_arb_asserts rr_arb_asserts_i (
   .clock (clock),
   .reset (reset),
   .req   (req),
   .hold  (hold),
   .stall (stall),
   .grant (grant)
);

// ==== rtl/rr_arb_top.sv ====
`timescale 1ns/1ps

module rr_arb_top (
   input  logic             clock,
   input  logic             reset,
   input  rr_pkg::apb_req_t apb_in,
   output rr_pkg::apb_rsp_t apb_out
);
   import rr_pkg::*;

   logic [num_req-1:0]        push;
   logic [7:0]                push_data;
   logic [num_req-1:0]        req;
   logic [num_req-1:0]        slot_full;
   logic [num_req-1:0][7:0]   slot_head;
   logic [num_req-1:0]        grant;
   logic                      grant_valid;
   logic                      hold;
   logic                      log_pop;
   logic                      log_full;
   logic [log_count_bits-1:0] log_count;
   grant_rec_t                rec;
   grant_rec_t                log_head;

   rr_apb_regs rr_apb_regs_i (
      .clock     (clock),
      .reset     (reset),
      .apb_in    (apb_in),
      .apb_out   (apb_out),
      .req       (req),
      .slot_full (slot_full),
      .log_head  (log_head),
      .log_count (log_count),
      .push      (push),
      .push_data (push_data),
      .hold      (hold),
      .log_pop   (log_pop)
   );

   for (genvar i = 0; i < num_req; i++) begin : g_slot
      rr_req_slot rr_req_slot_i (
         .clock     (clock),
         .reset     (reset),
         .push      (push[i]),
         .push_data (push_data),
         .pop       (grant[i]),  // a granted slot gives up its head.
         .req       (req[i]),
         .full      (slot_full[i]),
         .head      (slot_head[i])
      );
   end

   rr_arbiter8 rr_arbiter8_i (
      .clock       (clock),
      .reset       (reset),
      .req         (req),
      .hold        (hold),
      .stall       (log_full),  // a full log stops arbitration.
      .slot_head   (slot_head),
      .grant       (grant),
      .grant_valid (grant_valid),
      .rec         (rec)
   );

   rr_grant_log rr_grant_log_i (
      .clock  (clock),
      .reset  (reset),
      .push   (grant_valid),
      .rec_in (rec),
      .pop    (log_pop),
      .head   (log_head),
      .full   (log_full),
      .count  (log_count)
   );

endmodule

// ==== rtl/rr_grant_log.sv ====
`timescale 1ns/1ps

module rr_grant_log (
   input  logic                              clock,
   input  logic                              reset,
   input  logic                              push,
   input  rr_pkg::grant_rec_t                rec_in,
   input  logic                              pop,
   output rr_pkg::grant_rec_t                head,
   output logic                              full,
   output logic [rr_pkg::log_count_bits-1:0] count
);
   import rr_pkg::*;

   grant_rec_t [log_depth-1:0]     mem;
   logic [$clog2(log_depth)-1:0]   wr_ptr;
   logic [$clog2(log_depth)-1:0]   rd_ptr;
   logic                           do_push;
   logic                           do_pop;

   assign full = (count == log_count_bits'(log_depth));
   assign head = mem[rd_ptr];

   assign do_push = push & ~full;
   assign do_pop  = pop & (count != '0);

   always_ff @(posedge clock) begin
      if (do_push) begin
         mem[wr_ptr] <= rec_in;
      end
   end

   always_ff @(posedge clock or negedge reset) begin
      if (!reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         // a push and a pop together leave the count where it was.
         if (do_push && !do_pop) begin
            count <= count + 1'b1;
         end else if (do_pop && !do_push) begin
            count <= count - 1'b1;
         end
      end
   end

endmodule

// ==== rtl/rr_arbiter8.sv ====
`timescale 1ns/1ps

module rr_arbiter8 (
   input  logic                                 clock,
   input  logic                                 reset,
   input  logic [rr_pkg::num_req-1:0]           req,
   input  logic                                 hold,
   input  logic                                 stall,
   input  logic [rr_pkg::num_req-1:0][7:0]      slot_head,
   output logic [rr_pkg::num_req-1:0]           grant,
   output logic                                 grant_valid,
   output rr_pkg::grant_rec_t                   rec
);
   import rr_pkg::*;

   logic [num_req-1:0]      req_eff;
   logic [req_idx_bits-1:0] last_idx;
   logic [req_idx_bits-1:0] cand;
   logic [req_idx_bits-1:0] grant_idx;
   logic                    found;

   // nothing is granted while software holds or the log is full.
   assign req_eff = req & {num_req{~(hold | stall)}};

   // the search runs downward from just below the last grant and ends on it.
   // a reset value of 0 makes the first search start at 7.
   always_comb begin
      found     = 1'b0;
      grant_idx = '0;
      cand      = '0;
      for (int k = 1; k <= num_req; k++) begin
         cand = last_idx - req_idx_bits'(k);  // k of 8 wraps back to the last index.
         if (!found && req_eff[cand]) begin
            found     = 1'b1;
            grant_idx = cand;
         end
      end
   end

   always_comb begin
      grant = '0;
      if (found) begin
         grant[grant_idx] = 1'b1;
      end
   end

   assign grant_valid = found;
   assign rec.idx     = grant_idx;
   assign rec.data    = slot_head[grant_idx];  // head of the granted slot.

   always_ff @(posedge clock or negedge reset) begin
      if (!reset) begin
         last_idx <= '0;
      end else if (found) begin
         last_idx <= grant_idx;  // an idle cycle keeps the rotation point.
      end
   end

endmodule

// ==== rtl/rr_req_slot.sv ====
`timescale 1ns/1ps

module rr_req_slot (
   input  logic       clock,
   input  logic       reset,
   input  logic       push,
   input  logic [7:0] push_data,
   input  logic       pop,
   output logic       req,
   output logic       full,
   output logic [7:0] head
);
   import rr_pkg::*;

   logic [slot_depth-1:0][7:0]         mem;
   logic [$clog2(slot_depth)-1:0]      wr_ptr;
   logic [$clog2(slot_depth)-1:0]      rd_ptr;
   logic [$clog2(slot_depth+1)-1:0]    count;
   logic                               do_push;
   logic                               do_pop;

   assign req  = (count != '0);
   assign full = (count == slot_depth);
   assign head = mem[rd_ptr];

   assign do_push = push & ~full;
   assign do_pop  = pop & req;

   always_ff @(posedge clock) begin
      if (do_push) begin
         mem[wr_ptr] <= push_data;
      end
   end

   always_ff @(posedge clock or negedge reset) begin
      if (!reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;  // depth is a power of two, so pointers wrap.
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         if (do_push && !do_pop) begin
            count <= count + 1'b1;
         end else if (do_pop && !do_push) begin
            count <= count - 1'b1;
         end
      end
   end

endmodule

// ==== rtl/rr_apb_regs.sv ====
`timescale 1ns/1ps

module rr_apb_regs (
   input  logic                              clock,
   input  logic                              reset,
   input  rr_pkg::apb_req_t                  apb_in,
   output rr_pkg::apb_rsp_t                  apb_out,
   input  logic [rr_pkg::num_req-1:0]        req,
   input  logic [rr_pkg::num_req-1:0]        slot_full,
   input  rr_pkg::grant_rec_t                log_head,
   input  logic [rr_pkg::log_count_bits-1:0] log_count,
   output logic [rr_pkg::num_req-1:0]        push,
   output logic [7:0]                        push_data,
   output logic                              hold,
   output logic                              log_pop
);
   import rr_pkg::*;

   reg_addr_e               addr;
   logic                    access;
   logic                    wr_access;
   logic                    rd_access;
   logic                    is_slot;
   logic [7:0]              slot_off;
   logic [req_idx_bits-1:0] slot_idx;
   logic                    log_valid;

   assign addr      = reg_addr_e'(apb_in.paddr);
   assign access    = apb_in.psel & apb_in.penable;  // every access ends in its access phase.
   assign wr_access = access & apb_in.pwrite;
   assign rd_access = access & ~apb_in.pwrite;

   // slot addresses are word aligned between the first and the last slot.
   assign is_slot  = (apb_in.paddr >= addr_slot_base) && (apb_in.paddr <= addr_slot_end) &&
                     (apb_in.paddr[1:0] == 2'b00);
   assign slot_off = apb_in.paddr - addr_slot_base;
   assign slot_idx = slot_off[req_idx_bits+1:2];

   assign log_valid = (log_count != '0);
   assign push_data = apb_in.pwdata[7:0];

   always_comb begin
      push = '0;
      if (wr_access && is_slot && !slot_full[slot_idx]) begin
         push[slot_idx] = 1'b1;  // a full slot keeps what it has.
      end
   end

   assign log_pop = rd_access && (addr == addr_log_pop) && log_valid;

   always_ff @(posedge clock or negedge reset) begin
      if (!reset) begin
         hold <= 1'b0;
      end else if (wr_access && (addr == addr_ctrl)) begin
         hold <= apb_in.pwdata[0];
      end
   end

   always_comb begin
      apb_out.prdata = '0;
      if (rd_access) begin
         case (addr)
            addr_ctrl: begin
               apb_out.prdata = {31'b0, hold};
            end
            addr_status: begin
               apb_out.prdata = {20'b0, log_count, req};
            end
            addr_log_pop: begin
               if (log_valid) begin
                  apb_out.prdata = {1'b1, 20'b0, log_head.idx, log_head.data};
               end
            end
            default: begin
               apb_out.prdata = '0;  // slots are write only.
            end
         endcase
      end
   end

   assign apb_out.pready = 1'b1;

   // errors come from a full slot or a write to a read-only or unmapped address.
   assign apb_out.pslverr = wr_access &&
                            ((is_slot && slot_full[slot_idx]) ||
                             (!is_slot && (addr != addr_ctrl)));

endmodule

// ==== rtl/rr_pkg.sv ====
package rr_pkg;

   localparam int num_req        = 8;
   localparam int req_idx_bits   = 3;
   localparam int slot_depth     = 2;
   localparam int log_depth      = 8;
   localparam int log_count_bits = 4;

   // register map, byte addresses on the 8-bit apb address bus.
   typedef enum logic [7:0] {
      addr_ctrl      = 8'h00,  // bit 0 is the arbitration hold.
      addr_status    = 8'h04,  // request vector and log count.
      addr_log_pop   = 8'h08,  // reading pops the grant log.
      addr_slot_base = 8'h10,  // slot 0, slots follow every four bytes.
      addr_slot_end  = 8'h2c   // slot 7, the last data slot.
   } reg_addr_e;

   typedef struct packed {
      logic        psel;
      logic        penable;
      logic        pwrite;
      logic [7:0]  paddr;
      logic [31:0] pwdata;
   } apb_req_t;

   typedef struct packed {
      logic [31:0] prdata;
      logic        pready;
      logic        pslverr;
   } apb_rsp_t;

   typedef struct packed {
      logic [req_idx_bits-1:0] idx;
      logic [7:0]              data;
   } grant_rec_t;

endpackage
